// File: Makefile
# Verilator build and run for the ping-pong frame buffer

VERILATOR  ?= verilator
TOP        ?= tb_pingpong
LINT_TOP   ?= pingpong_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(SIM_BIN) > $(LOG) 2>&1 || echo "Result: FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
verilog/pp_cfg_pkg.sv
verilog/pp_types_pkg.sv
verilog/pp_bank.sv
verilog/pp_write_ctrl.sv
verilog/pp_read_ctrl.sv
verilog/pingpong_top.sv
tests/tb_pingpong.sv

// File: tests/pp_testdata.hex
// First line: sample count N in hex; then one 8-bit sample per line
// Four whole frames of 8 samples, then a tail of 4 that stays inside
24
3c
a7
01
fe
5d
92
c4
18
7b
e0
33
6a
0f
b5
d1
48
29
86
f3
5e
10
cb
77
a2
64
0d
9f
e8
41
b6
2c
55
99
ee
03
70

// File: tests/tb_pingpong.sv
`timescale 1ns/1ns

module tb_pingpong
    import pp_cfg_pkg::*, pp_types_pkg::*;
();

    localparam int TB_DEPTH    = 8;
    localparam int TB_BANKS    = 2;
    localparam int CLK_PERIOD  = 40;
    localparam int MAX_SAMPLES = 255;

    typedef enum int {READY_HIGH, READY_LOW, READY_RANDOM} ready_mode_t;

    logic        clk_25m;
    logic        sys_rst_n;
    logic        in_valid;
    sample_t     in_data;
    logic        in_ready;
    logic        out_valid;
    pp_out_t     out_word;
    logic        out_ready;

    logic [DATA_W-1:0] file_mem [0:MAX_SAMPLES];  // Entry 0 is the count
    int          n_samples;
    int          full_total;       // Samples that form whole frames
    int          acc_count;
    int          out_count;
    int          exp_limit;        // Words allowed in the running test
    int          err_count;
    int          tests_passed;
    int          tests_failed;
    integer      seed;
    ready_mode_t ready_mode;

    pingpong_top #(
        .BANK_DEPTH (TB_DEPTH),
        .NUM_BANKS  (TB_BANKS)
    ) i_dut (
        .clk_25m   (clk_25m),
        .sys_rst_n (sys_rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_ready (out_ready)
    );

    initial begin
        clk_25m = 1'b0;
        forever #(CLK_PERIOD / 2) clk_25m = ~clk_25m;
    end

    function automatic pp_out_t expected_word(input int k);
        pp_out_t w;
        w.data = file_mem[k + 1];
        w.bank = BANK_W'((k / TB_DEPTH) % TB_BANKS);  // Frames alternate over banks
        w.last = ((k % TB_DEPTH) == TB_DEPTH - 1);
        return w;
    endfunction

    task automatic check_word(input pp_out_t got, input pp_out_t exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s got data %h bank %0d last %b, expected %h bank %0d last %b",
                     $time, what, got.data, got.bank, got.last, exp.data, exp.bank, exp.last);
            err_count++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    // Handshakes are sampled mid-cycle, where both sides are settled
    always @(negedge clk_25m) begin
        if (sys_rst_n) begin
            if (in_valid && in_ready) begin
                acc_count++;
            end
            if (out_valid && out_ready) begin
                if (out_count < exp_limit) begin
                    check_word(out_word, expected_word(out_count),
                               $sformatf("word %0d", out_count));
                end else begin
                    $display("Fail %0t ns: unexpected extra word %0d", $time, out_count);
                    err_count++;
                end
                out_count++;
            end
        end
    end

    always @(posedge clk_25m) begin
        #2;
        case (ready_mode)
            READY_HIGH: out_ready = 1'b1;
            READY_LOW:  out_ready = 1'b0;
            default:    out_ready = 1'($random(seed));
        endcase
    end

    task automatic apply_reset();
        @(posedge clk_25m);
        #2;
        sys_rst_n = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        acc_count = 0;
        out_count = 0;
        repeat (10) @(posedge clk_25m);
        #2;
        sys_rst_n = 1'b1;
    endtask

    // Offers samples in file order until enough are taken or the window closes
    task automatic drive_window(input int max_samples, input int max_cycles);
        int   sent;
        int   cycles;
        logic take;
        sent   = 0;
        cycles = 0;
        while (sent < max_samples && cycles < max_cycles) begin
            in_valid = 1'b1;
            in_data  = file_mem[sent + 1];
            @(negedge clk_25m);
            take = in_ready;
            @(posedge clk_25m);
            #2;
            cycles++;
            if (take) begin
                sent++;
            end
        end
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    task automatic wait_outputs(input int target);
        while (out_count < target) begin
            @(posedge clk_25m);
        end
        #2;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_25m);
        #2;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        sys_rst_n    = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b0;
        ready_mode   = READY_HIGH;
        seed         = 32'h6de5bcaa;
        acc_count    = 0;
        out_count    = 0;
        exp_limit    = 0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        $readmemh("tests/pp_testdata.hex", file_mem);
        if ($isunknown(file_mem[0])) begin
            $display("Test data could not be read from tests/pp_testdata.hex");
            tests_failed++;
        end else begin
            n_samples  = int'(file_mem[0]);
            full_total = (n_samples / TB_DEPTH) * TB_DEPTH;  // Tail never leaves

            apply_reset();
            errs = err_count;
            check_flag(out_valid, 1'b0, "out_valid after reset");
            check_flag(in_ready, 1'b1, "in_ready after reset");
            finish_test("reset state", errs);

            errs      = err_count;
            exp_limit = full_total;
            drive_window(n_samples, n_samples * 2);
            wait_outputs(full_total);
            idle_cycles(2 * TB_DEPTH);
            check_count(acc_count, n_samples, "accepted samples");
            check_count(out_count, full_total, "emitted words");
            finish_test("in-order stream", errs);

            @(negedge clk_25m);
            ready_mode = READY_LOW;
            apply_reset();
            errs      = err_count;
            exp_limit = TB_BANKS * TB_DEPTH;
            drive_window(n_samples, TB_BANKS * TB_DEPTH + 16);
            check_count(acc_count, TB_BANKS * TB_DEPTH, "samples taken while stalled");
            check_flag(in_ready, 1'b0, "in_ready with every bank full");
            check_count(out_count, 0, "words emitted while stalled");
            @(negedge clk_25m);
            ready_mode = READY_HIGH;              // Release the sink
            wait_outputs(exp_limit);
            idle_cycles(2 * TB_DEPTH);
            check_count(out_count, exp_limit, "words after release");
            finish_test("full back-pressure", errs);

            @(negedge clk_25m);
            ready_mode = READY_RANDOM;
            apply_reset();
            errs      = err_count;
            exp_limit = full_total;
            drive_window(n_samples, n_samples * 4);
            wait_outputs(full_total);
            idle_cycles(2 * TB_DEPTH);
            check_count(acc_count, n_samples, "accepted samples");
            check_count(out_count, full_total, "emitted words");
            finish_test("random back-pressure", errs);
        end

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog, scaled to the sample count
    initial begin
        int limit;
        #1;
        limit = $isunknown(file_mem[0]) ? 200 : int'(file_mem[0]) * 4 + 200;
        repeat (limit) @(posedge clk_25m);
        $display("The run timed out after %0d clock periods", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: verilog/pingpong_top.sv
`timescale 1ns/1ns

module pingpong_top
    import pp_cfg_pkg::*, pp_types_pkg::*;
#(
    parameter int BANK_DEPTH = DEF_BANK_DEPTH,
    parameter int NUM_BANKS  = DEF_NUM_BANKS
) (
    input  logic    clk_25m,
    input  logic    sys_rst_n,
    input  logic    in_valid,
    input  sample_t in_data,
    output logic    in_ready,
    output logic    out_valid,
    output pp_out_t out_word,
    input  logic    out_ready
);

    bank_wr_t             bank_wr [NUM_BANKS];
    sample_t              rd_data [NUM_BANKS];
    logic [ADDR_W-1:0]    rd_addr;     // Shared by all banks
    logic [NUM_BANKS-1:0] bank_req;    // Writer to reader, bank full
    logic [NUM_BANKS-1:0] bank_ack;    // Reader to writer, bank drained

    pp_write_ctrl #(
        .BANK_DEPTH (BANK_DEPTH),
        .NUM_BANKS  (NUM_BANKS)
    ) i_write_ctrl (
        .clk_25m   (clk_25m),
        .sys_rst_n (sys_rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .bank_wr   (bank_wr),
        .bank_req  (bank_req),
        .bank_ack  (bank_ack)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        pp_bank #(
            .BANK_DEPTH (BANK_DEPTH)
        ) i_bank (
            .clk_25m (clk_25m),
            .wr      (bank_wr[i]),
            .rd_addr (rd_addr),
            .rd_data (rd_data[i])
        );
    end

    pp_read_ctrl #(
        .BANK_DEPTH (BANK_DEPTH),
        .NUM_BANKS  (NUM_BANKS)
    ) i_read_ctrl (
        .clk_25m   (clk_25m),
        .sys_rst_n (sys_rst_n),
        .bank_req  (bank_req),
        .bank_ack  (bank_ack),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_ready (out_ready)
    );

endmodule

// File: verilog/pp_bank.sv
`timescale 1ns/1ns

module pp_bank
    import pp_cfg_pkg::*, pp_types_pkg::*;
#(
    parameter int BANK_DEPTH = DEF_BANK_DEPTH
) (
    input  logic              clk_25m,
    input  bank_wr_t          wr,
    input  logic [ADDR_W-1:0] rd_addr,
    output sample_t           rd_data
);

    // Address bits that actually select a word
    localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    sample_t mem [BANK_DEPTH];

    always_ff @(posedge clk_25m) begin
        if (wr.en) begin
            mem[wr.addr[IDX_W-1:0]] <= wr.data;
        end
    end

    assign rd_data = mem[rd_addr[IDX_W-1:0]];  // Combinational read port

    // The writer must wrap before the end of the frame
    assert property (@(posedge clk_25m) wr.en |-> (int'(wr.addr) < BANK_DEPTH))
        else $error("Bank write at address %0d beyond depth %0d", wr.addr, BANK_DEPTH);

endmodule

// File: verilog/pp_cfg_pkg.sv
package pp_cfg_pkg;

    // Sample format
    localparam int DATA_W = 8;          // One sample per word

    // Default frame geometry, overridden from the top level
    localparam int DEF_BANK_DEPTH = 100;    // Samples per frame
    localparam int DEF_NUM_BANKS  = 2;      // Classic ping-pong

    // Index widths
    localparam int ADDR_W = 8;          // Depths up to 256
    localparam int BANK_W = 4;          // Up to 16 banks

endpackage

// File: verilog/pp_read_ctrl.sv
`timescale 1ns/1ns

module pp_read_ctrl
    import pp_cfg_pkg::*, pp_types_pkg::*;
#(
    parameter int BANK_DEPTH = DEF_BANK_DEPTH,
    parameter int NUM_BANKS  = DEF_NUM_BANKS
) (
    input  logic                 clk_25m,
    input  logic                 sys_rst_n,
    input  logic [NUM_BANKS-1:0] bank_req,
    output logic [NUM_BANKS-1:0] bank_ack,
    output logic [ADDR_W-1:0]    rd_addr,
    input  sample_t              rd_data [NUM_BANKS],
    output logic                 out_valid,
    output pp_out_t              out_word,
    input  logic                 out_ready
);

    typedef enum logic [1:0] {
        S_WAIT,     // Current bank not yet full
        S_DRAIN,    // Walking the bank addresses
        S_ACK,      // Last word loaded, raise ack
        S_REL       // Wait for req to drop
    } state_t;

    state_t               state;
    logic [BANK_W-1:0]    cur_bank;    // Bank being drained
    logic [NUM_BANKS-1:0] cur_sel;
    logic                 cur_req;
    sample_t              cur_data;
    logic                 rd_last;
    logic                 load;        // Output register takes a word

    assign cur_sel = NUM_BANKS'(1) << cur_bank;
    assign cur_req = |(bank_req & cur_sel);
    assign rd_last = (rd_addr == ADDR_W'(BANK_DEPTH - 1));
    assign load    = ((state == S_WAIT) || (state == S_DRAIN)) && cur_req &&
                     (!out_valid || out_ready);

    // Read data of the current bank
    always_comb begin
        cur_data = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (cur_sel[i]) begin
                cur_data = rd_data[i];
            end
        end
    end

    always_ff @(posedge clk_25m or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= S_WAIT;
            cur_bank  <= '0;
            rd_addr   <= '0;
            bank_ack  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;             // Consumed, nothing new
            end

            case (state)
                S_WAIT, S_DRAIN: begin
                    if (load) begin
                        rd_addr <= rd_last ? '0 : rd_addr + 1'b1;
                        state   <= rd_last ? S_ACK : S_DRAIN;
                    end
                end
                S_ACK: begin
                    bank_ack <= bank_ack | cur_sel;
                    state    <= S_REL;
                end
                S_REL: begin
                    if (!cur_req) begin
                        bank_ack <= bank_ack & ~cur_sel;  // Bank free for the writer
                        cur_bank <= (cur_bank == BANK_W'(NUM_BANKS - 1)) ?
                                    '0 : cur_bank + 1'b1;
                        state    <= S_WAIT;
                    end
                end
                default: state <= S_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk_25m) begin
        if (load) begin
            out_word.data <= cur_data;
            out_word.bank <= cur_bank;
            out_word.last <= rd_last;
        end
    end

    // The writer keeps req up until the whole bank is read and acked
    assert property (@(posedge clk_25m) disable iff (!sys_rst_n)
        ((state == S_DRAIN) || (state == S_ACK)) |-> cur_req)
        else $error("Req of bank %0d dropped during drain", cur_bank);

endmodule

// File: verilog/pp_types_pkg.sv
package pp_types_pkg;

    import pp_cfg_pkg::*;

    typedef logic [DATA_W-1:0] sample_t;

    // Write port of one RAM bank
    typedef struct packed {
        logic              en;         // Write strobe
        logic [ADDR_W-1:0] addr;       // Word address inside the bank
        sample_t           data;
    } bank_wr_t;

    // Word on the output stream
    typedef struct packed {
        sample_t           data;
        logic [BANK_W-1:0] bank;       // Bank the word was read from
        logic              last;       // Final word of the frame
    } pp_out_t;

endpackage

// File: verilog/pp_write_ctrl.sv
`timescale 1ns/1ns

module pp_write_ctrl
    import pp_cfg_pkg::*, pp_types_pkg::*;
#(
    parameter int BANK_DEPTH = DEF_BANK_DEPTH,
    parameter int NUM_BANKS  = DEF_NUM_BANKS
) (
    input  logic                 clk_25m,
    input  logic                 sys_rst_n,
    input  logic                 in_valid,
    input  sample_t              in_data,
    output logic                 in_ready,
    output bank_wr_t             bank_wr [NUM_BANKS],
    output logic [NUM_BANKS-1:0] bank_req,
    input  logic [NUM_BANKS-1:0] bank_ack
);

    logic [ADDR_W-1:0]    wr_addr;     // Next word of the bank being filled
    logic [BANK_W-1:0]    cur_bank;    // Bank being filled
    logic [NUM_BANKS-1:0] cur_sel;     // One-hot of cur_bank
    logic [NUM_BANKS-1:0] wr_en;
    logic                 accept;
    logic                 wr_last;

    assign cur_sel  = NUM_BANKS'(1) << cur_bank;
    assign in_ready = ~|(cur_sel & (bank_req | bank_ack));  // Bank idle on both sides
    assign accept   = in_valid & in_ready;
    assign wr_last  = (wr_addr == ADDR_W'(BANK_DEPTH - 1));
    assign wr_en    = accept ? cur_sel : '0;

    // Address and data are shared, only the strobe picks the bank
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_wr
        assign bank_wr[i].en   = wr_en[i];
        assign bank_wr[i].addr = wr_addr;
        assign bank_wr[i].data = in_data;
    end

    always_ff @(posedge clk_25m or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_addr  <= '0;
            cur_bank <= '0;
            bank_req <= '0;
        end else begin
            // Hand over a full bank, withdraw req once the reader acks
            bank_req <= (bank_req & ~bank_ack) | ((accept && wr_last) ? cur_sel : '0);
            if (accept) begin
                if (wr_last) begin
                    wr_addr  <= '0;
                    cur_bank <= (cur_bank == BANK_W'(NUM_BANKS - 1)) ? '0 : cur_bank + 1'b1;
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

    // The reader only acks a bank that was handed over
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_ack_chk
        assert property (@(posedge clk_25m) disable iff (!sys_rst_n)
            $rose(bank_ack[i]) |-> bank_req[i])
            else $error("Ack on bank %0d without a pending req", i);
    end

endmodule
